//--- logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  alu_op_t;

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_SLTU   = 4'd4;
    localparam alu_op_t ALU_XOR    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_OR     = 4'd8;
    localparam alu_op_t ALU_AND    = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10;  // LUI

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // Decode to execute
    typedef struct packed {
        logic       valid;
        word_t      pc;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        word_t      rs1_val;
        word_t      rs2_val;
        word_t      imm;
        alu_op_t    alu_op;
        logic       a_is_pc;
        logic       b_is_imm;
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic [2:0] funct3;
        logic       reg_write;
        logic       invalid;
    } dec_pkt_t;

    // Execute to commit
    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        word_t    wdata;
        logic     reg_write;  // Already clear for trap and x0
        logic     trap;
        logic     redirect;
        word_t    next_pc;
    } res_pkt_t;

endpackage

`default_nettype wire

//--- logic/inst_decode.sv
`default_nettype none

module inst_decode #(
    parameter int NUM_REGS = 32
) (
    input  logic             inst_valid,
    input  rv_pkg::word_t    inst,
    input  rv_pkg::word_t    inst_pc,
    input  rv_pkg::word_t    rs1_val,
    input  rv_pkg::word_t    rs2_val,
    output rv_pkg::reg_idx_t rs1,
    output rv_pkg::reg_idx_t rs2,
    output rv_pkg::dec_pkt_t dec
);

    localparam logic [5:0] REG_LIMIT = 6'(NUM_REGS);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    rv_pkg::reg_idx_t rd;

    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_u;
    rv_pkg::word_t imm_j;
    rv_pkg::word_t imm_b;
    rv_pkg::word_t imm;

    logic opc_lui, opc_auipc, opc_jal, opc_jalr, opc_branch, opc_op_imm, opc_op;
    logic ok_jalr, ok_branch, ok_op_imm, ok_op, enc_ok;
    logic uses_rd, uses_rs1, uses_rs2;
    logic bad_idx, invalid;
    rv_pkg::alu_op_t alu_op;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'd0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

    always_comb begin
        case (opcode)
            rv_pkg::OPC_LUI,
            rv_pkg::OPC_AUIPC:  imm = imm_u;
            rv_pkg::OPC_JAL:    imm = imm_j;
            rv_pkg::OPC_BRANCH: imm = imm_b;
            default:            imm = imm_i;  // OP-IMM and JALR
        endcase
    end

    assign opc_lui    = opcode == rv_pkg::OPC_LUI;
    assign opc_auipc  = opcode == rv_pkg::OPC_AUIPC;
    assign opc_jal    = opcode == rv_pkg::OPC_JAL;
    assign opc_jalr   = opcode == rv_pkg::OPC_JALR;
    assign opc_branch = opcode == rv_pkg::OPC_BRANCH;
    assign opc_op_imm = opcode == rv_pkg::OPC_OP_IMM;
    assign opc_op     = opcode == rv_pkg::OPC_OP;

    assign ok_jalr   = opc_jalr && funct3 == 3'b000;
    assign ok_branch = opc_branch && funct3 != 3'b010 && funct3 != 3'b011;
    assign ok_op_imm = opc_op_imm && (
        (funct3 != 3'b001 && funct3 != 3'b101) ||
        (funct3 == 3'b001 && funct7 == 7'b0000000) ||
        (funct3 == 3'b101 && (funct7 == 7'b0000000 || funct7 == 7'b0100000)));
    assign ok_op = opc_op && (
        funct7 == 7'b0000000 ||
        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));

    assign enc_ok = opc_lui || opc_auipc || opc_jal || ok_jalr ||
                    ok_branch || ok_op_imm || ok_op;

    // Register indices beyond NUM_REGS only matter for RV32E
    assign uses_rd  = opc_lui || opc_auipc || opc_jal || opc_jalr || opc_op_imm || opc_op;
    assign uses_rs1 = opc_jalr || opc_branch || opc_op_imm || opc_op;
    assign uses_rs2 = opc_branch || opc_op;
    assign bad_idx  = (uses_rd  && {1'b0, rd}  >= REG_LIMIT) ||
                      (uses_rs1 && {1'b0, rs1} >= REG_LIMIT) ||
                      (uses_rs2 && {1'b0, rs2} >= REG_LIMIT);

    assign invalid = !enc_ok || bad_idx;

    always_comb begin
        alu_op = rv_pkg::ALU_ADD;  // Jumps, AUIPC
        if (opc_lui) begin
            alu_op = rv_pkg::ALU_PASS_B;
        end else if (opc_op_imm || opc_op) begin
            case (funct3)
                3'b000:  alu_op = (opc_op && funct7[5]) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                3'b001:  alu_op = rv_pkg::ALU_SLL;
                3'b010:  alu_op = rv_pkg::ALU_SLT;
                3'b011:  alu_op = rv_pkg::ALU_SLTU;
                3'b100:  alu_op = rv_pkg::ALU_XOR;
                3'b101:  alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                3'b110:  alu_op = rv_pkg::ALU_OR;
                default: alu_op = rv_pkg::ALU_AND;
            endcase
        end
    end

    always_comb begin
        dec.valid     = inst_valid;
        dec.pc        = inst_pc;
        dec.rd        = rd;
        dec.rs1       = rs1;
        dec.rs2       = rs2;
        dec.rs1_val   = rs1_val;
        dec.rs2_val   = rs2_val;
        dec.imm       = imm;
        dec.alu_op    = alu_op;
        dec.a_is_pc   = opc_auipc || opc_jal;
        dec.b_is_imm  = !(opc_op || opc_branch);
        dec.is_branch = opc_branch;
        dec.is_jal    = opc_jal;
        dec.is_jalr   = opc_jalr;
        dec.funct3    = funct3;
        dec.reg_write = uses_rd && !invalid && rd != '0;
        dec.invalid   = invalid;
    end

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`default_nettype none

module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  logic             we,
    input  rv_pkg::reg_idx_t waddr,
    input  rv_pkg::word_t    wdata,
    output rv_pkg::word_t    rs1_val,
    output rv_pkg::word_t    rs2_val
);

    localparam logic [5:0] REG_LIMIT = 6'(NUM_REGS);

    rv_pkg::word_t regs [NUM_REGS];

    function automatic rv_pkg::word_t read_port(rv_pkg::reg_idx_t idx);
        if (idx == '0 || {1'b0, idx} >= REG_LIMIT) begin
            return '0;
        end else if (we && waddr == idx) begin
            return wdata;  // Write-through
        end
        return regs[idx];
    endfunction

    always_comb rs1_val = read_port(rs1);
    always_comb rs2_val = read_port(rs2);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0 && {1'b0, waddr} < REG_LIMIT) begin
            regs[waddr] <= wdata;
        end
    end

    a_write_idx: assert property (@(posedge clk) disable iff (!rst_n)
        we |-> (waddr != '0 && {1'b0, waddr} < REG_LIMIT));

endmodule

`default_nettype wire

//--- logic/alu_execute.sv
`default_nettype none

module alu_execute (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::dec_pkt_t dec,
    input  rv_pkg::res_pkt_t fwd,
    output rv_pkg::res_pkt_t res
);

    rv_pkg::dec_pkt_t ex;
    logic             ex_valid;

    logic          fwd_ok;
    rv_pkg::word_t rs1_fwd;
    rv_pkg::word_t rs2_fwd;
    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    rv_pkg::word_t alu_y;
    rv_pkg::word_t pc_plus4;
    rv_pkg::word_t next_pc;
    logic          br_taken;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec.valid;
        end
    end

    always_ff @(posedge clk) begin
        ex <= dec;
    end

    // Commit stage result overrides the stale register read
    assign fwd_ok  = fwd.valid && fwd.reg_write;
    assign rs1_fwd = (fwd_ok && fwd.rd == ex.rs1) ? fwd.wdata : ex.rs1_val;
    assign rs2_fwd = (fwd_ok && fwd.rd == ex.rs2) ? fwd.wdata : ex.rs2_val;

    assign op_a = ex.a_is_pc ? ex.pc : rs1_fwd;
    assign op_b = ex.b_is_imm ? ex.imm : rs2_fwd;

    always_comb begin
        case (ex.alu_op)
            rv_pkg::ALU_ADD:  alu_y = op_a + op_b;
            rv_pkg::ALU_SUB:  alu_y = op_a - op_b;
            rv_pkg::ALU_SLL:  alu_y = op_a << op_b[4:0];
            rv_pkg::ALU_SLT:  alu_y = {31'd0, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_SLTU: alu_y = {31'd0, op_a < op_b};
            rv_pkg::ALU_XOR:  alu_y = op_a ^ op_b;
            rv_pkg::ALU_SRL:  alu_y = op_a >> op_b[4:0];
            rv_pkg::ALU_SRA:  alu_y = rv_pkg::word_t'($signed(op_a) >>> op_b[4:0]);
            rv_pkg::ALU_OR:   alu_y = op_a | op_b;
            rv_pkg::ALU_AND:  alu_y = op_a & op_b;
            default:          alu_y = op_b;
        endcase
    end

    always_comb begin
        case (ex.funct3)
            3'b000:  br_taken = rs1_fwd == rs2_fwd;
            3'b001:  br_taken = rs1_fwd != rs2_fwd;
            3'b100:  br_taken = $signed(rs1_fwd) < $signed(rs2_fwd);
            3'b101:  br_taken = $signed(rs1_fwd) >= $signed(rs2_fwd);
            3'b110:  br_taken = rs1_fwd < rs2_fwd;
            default: br_taken = rs1_fwd >= rs2_fwd;
        endcase
    end

    always_comb begin
        pc_plus4 = ex.pc + 32'd4;
        next_pc  = pc_plus4;
        if (!ex.invalid) begin
            if (ex.is_jal) begin
                next_pc = alu_y;  // pc + imm
            end else if (ex.is_jalr) begin
                next_pc = {alu_y[31:1], 1'b0};
            end else if (ex.is_branch && br_taken) begin
                next_pc = ex.pc + ex.imm;
            end
        end
    end

    always_comb begin
        res.valid     = ex_valid;
        res.pc        = ex.pc;
        res.rd        = ex.rd;
        res.reg_write = ex.reg_write;
        res.wdata     = !ex.reg_write ? '0 : (ex.is_jal || ex.is_jalr) ? pc_plus4 : alu_y;
        res.trap      = ex.invalid;
        res.redirect  = next_pc != pc_plus4;
        res.next_pc   = next_pc;
    end

    a_trap_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        res.valid |-> !(res.trap && res.reg_write));

endmodule

`default_nettype wire

//--- logic/result_commit.sv
`default_nettype none

module result_commit (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::res_pkt_t res,
    output rv_pkg::res_pkt_t cur,
    output logic             we,
    output rv_pkg::reg_idx_t waddr,
    output rv_pkg::word_t    wdata,
    output logic             retire_valid,
    output rv_pkg::word_t    retire_pc,
    output rv_pkg::reg_idx_t retire_rd,
    output rv_pkg::word_t    retire_wdata,
    output logic             retire_we,
    output logic             retire_trap,
    output logic             redirect,
    output rv_pkg::word_t    redirect_pc
);

    rv_pkg::res_pkt_t cm;
    logic             cm_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cm_valid <= 1'b0;
        end else begin
            cm_valid <= res.valid;
        end
    end

    always_ff @(posedge clk) begin
        cm <= res;
    end

    always_comb begin
        cur       = cm;
        cur.valid = cm_valid;  // Forwarding source
    end

    assign we    = cm_valid && cm.reg_write;
    assign waddr = cm.rd;
    assign wdata = cm.wdata;

    assign retire_valid = cm_valid;
    assign retire_pc    = cm.pc;
    assign retire_rd    = cm.rd;
    assign retire_wdata = cm.wdata;
    assign retire_we    = we;
    assign retire_trap  = cm_valid && cm.trap;
    assign redirect     = cm_valid && cm.redirect;
    assign redirect_pc  = cm.next_pc;

    a_redirect_retire: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> retire_valid && !retire_trap);

endmodule

`default_nettype wire

//--- logic/rv_core_top.sv
`default_nettype none

module rv_core_top #(
    parameter int NUM_REGS = 32  // 16 for RV32E
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             inst_valid,
    input  rv_pkg::word_t    inst,
    input  rv_pkg::word_t    inst_pc,
    output logic             retire_valid,
    output rv_pkg::word_t    retire_pc,
    output rv_pkg::reg_idx_t retire_rd,
    output rv_pkg::word_t    retire_wdata,
    output logic             retire_we,
    output logic             retire_trap,
    output logic             redirect,
    output rv_pkg::word_t    redirect_pc
);

    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::word_t    rs1_val;
    rv_pkg::word_t    rs2_val;
    rv_pkg::dec_pkt_t dec;
    rv_pkg::res_pkt_t res;
    rv_pkg::res_pkt_t cur;
    logic             we;
    rv_pkg::reg_idx_t waddr;
    rv_pkg::word_t    wdata;

    inst_decode #(.NUM_REGS(NUM_REGS)) inst_decode_i (
        .inst_valid, .inst, .inst_pc, .rs1_val, .rs2_val,
        .rs1, .rs2, .dec
    );

    reg_file #(.NUM_REGS(NUM_REGS)) reg_file_i (
        .clk, .rst_n, .rs1, .rs2, .we, .waddr, .wdata,
        .rs1_val, .rs2_val
    );

    alu_execute alu_execute_i (
        .clk, .rst_n, .dec, .fwd(cur), .res
    );

    result_commit result_commit_i (
        .clk, .rst_n, .res, .cur, .we, .waddr, .wdata,
        .retire_valid, .retire_pc, .retire_rd, .retire_wdata,
        .retire_we, .retire_trap, .redirect, .redirect_pc
    );

endmodule

`default_nettype wire

//--- bench/core_tb.sv
`default_nettype none

module core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_INSTS      = 300;
    localparam int TIMEOUT_CYCLES = 3 * NUM_INSTS + 40;

    typedef struct packed {
        logic [31:0]      due;  // Negedge count at which retirement is expected
        rv_pkg::word_t    pc;
        rv_pkg::reg_idx_t rd;
        rv_pkg::word_t    wdata;
        logic             we;
        logic             trap;
        logic             redirect;
        rv_pkg::word_t    next_pc;
    } exp_t;

    logic             clk;
    logic             rst_n;
    logic             inst_valid;
    rv_pkg::word_t    inst;
    rv_pkg::word_t    inst_pc;
    logic             retire_valid;
    rv_pkg::word_t    retire_pc;
    rv_pkg::reg_idx_t retire_rd;
    rv_pkg::word_t    retire_wdata;
    logic             retire_we;
    logic             retire_trap;
    logic             redirect;
    rv_pkg::word_t    redirect_pc;

    rv_pkg::word_t model_regs [32];
    exp_t          expect_q [$];
    int            ncyc = 0;
    int            errors = 0;
    int            retired = 0;

    rv_core_top #(.NUM_REGS(32)) rv_core_top_i (
        .clk, .rst_n, .inst_valid, .inst, .inst_pc,
        .retire_valid, .retire_pc, .retire_rd, .retire_wdata,
        .retire_we, .retire_trap, .redirect, .redirect_pc
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input rv_pkg::word_t exp_val,
                               input rv_pkg::word_t act_val);
        assert (exp_val === act_val) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h",
                     $time, name, exp_val, act_val);
        end
    endtask

    function automatic rv_pkg::word_t ref_alu(logic [2:0] f3, logic alt,
                                              rv_pkg::word_t a, rv_pkg::word_t b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];  // Shift amount from low 5 bits only
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return sa >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Architectural model, updates model_regs in program order
    task automatic predict_retire(input rv_pkg::word_t in, input rv_pkg::word_t pc,
                                  output exp_t e);
        rv_pkg::word_t a, b, imm_i, imm_b, imm_j, r;
        logic [2:0]    f3;
        logic [6:0]    f7;
        logic          ok, wr, taken;
        a     = model_regs[in[19:15]];
        b     = model_regs[in[24:20]];
        f3    = in[14:12];
        f7    = in[31:25];
        imm_i = {{20{in[31]}}, in[31:20]};
        imm_b = {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
        imm_j = {{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
        e         = '0;
        e.pc      = pc;
        e.rd      = in[11:7];
        e.next_pc = pc + 32'd4;
        ok        = 1'b1;
        wr        = 1'b1;
        taken     = 1'b0;
        r         = '0;
        case (in[6:0])
            rv_pkg::OPC_LUI:   r = {in[31:12], 12'h000};
            rv_pkg::OPC_AUIPC: r = pc + {in[31:12], 12'h000};
            rv_pkg::OPC_JAL: begin
                r         = pc + 32'd4;
                e.next_pc = pc + imm_j;
            end
            rv_pkg::OPC_JALR: begin
                ok        = f3 == 3'd0;
                r         = pc + 32'd4;
                e.next_pc = (a + imm_i) & ~32'd1;
            end
            rv_pkg::OPC_BRANCH: begin
                wr = 1'b0;
                case (f3)
                    3'd0:    taken = a == b;
                    3'd1:    taken = a != b;
                    3'd4:    taken = $signed(a) < $signed(b);
                    3'd5:    taken = $signed(a) >= $signed(b);
                    3'd6:    taken = a < b;
                    3'd7:    taken = a >= b;
                    default: ok = 1'b0;
                endcase
                if (taken) e.next_pc = pc + imm_b;
            end
            rv_pkg::OPC_OP_IMM: begin
                ok = (f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20);
                r  = ref_alu(f3, f3 == 3'd5 && f7[5], a, imm_i);
            end
            rv_pkg::OPC_OP: begin
                ok = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                r  = ref_alu(f3, f7[5], a, b);
            end
            default: ok = 1'b0;
        endcase
        if (!ok) begin
            e.trap    = 1'b1;
            wr        = 1'b0;
            e.next_pc = pc + 32'd4;
        end
        e.we       = wr && e.rd != 5'd0;
        e.wdata    = r;
        e.redirect = e.next_pc != pc + 32'd4;
        if (e.we) model_regs[e.rd] = r;
    endtask

    task automatic make_inst(output rv_pkg::word_t in);
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        logic [19:0] imm20;
        rd    = 5'($urandom_range(0, 7));  // x0..x7 keeps hazards frequent
        rs1   = 5'($urandom_range(0, 7));
        rs2   = 5'($urandom_range(0, 7));
        f3    = 3'($urandom);
        imm12 = 12'($urandom);
        imm20 = 20'($urandom);
        case ($urandom_range(0, 11))
            0, 1, 2: begin
                f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1)) ? 7'h20 : 7'h00;
                in = {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
            end
            3, 4: begin
                if (f3 == 3'd1) imm12[11:5] = 7'h00;
                if (f3 == 3'd5) imm12[11:5] = $urandom_range(0, 1) ? 7'h20 : 7'h00;
                in = {imm12, rs1, f3, rd, rv_pkg::OPC_OP_IMM};
            end
            5: in = {imm20, rd, rv_pkg::OPC_LUI};
            6: in = {imm20, rd, rv_pkg::OPC_AUIPC};
            7: in = {imm20, rd, rv_pkg::OPC_JAL};
            8: in = {imm12, rs1, 3'b000, rd, rv_pkg::OPC_JALR};
            9, 10: begin
                if (f3[2:1] == 2'b01) f3[2] = 1'b1;  // Skip reserved funct3
                in = {imm12[11:5], rs2, rs1, f3, imm12[4:0], rv_pkg::OPC_BRANCH};
            end
            default: begin
                case ($urandom_range(0, 7))
                    0: in = {imm12, rs1, f3, rd, 7'b0000011};                       // Load
                    1: in = {imm12[11:5], rs2, rs1, f3, imm12[4:0], 7'b0100011};    // Store
                    2: in = {imm12, rs1, f3 | 3'b001, rd, 7'b1110011};              // CSR
                    3: in = {7'b0000001, rs2, rs1, f3, rd, rv_pkg::OPC_OP};         // M ext
                    4: in = {7'h20, rs2, rs1, f3 | 3'b010, rd, rv_pkg::OPC_OP};
                    5: in = {imm12[11:5], rs2, rs1, {2'b01, f3[0]}, imm12[4:0],
                             rv_pkg::OPC_BRANCH};
                    6: in = {imm12, rs1, f3 | 3'b001, rd, rv_pkg::OPC_JALR};
                    default: in = {7'h20, imm12[4:0], rs1, 3'b001, rd, rv_pkg::OPC_OP_IMM};
                endcase
            end
        endcase
    endtask

    initial begin
        exp_t          e;
        rv_pkg::word_t pc;
        rv_pkg::word_t in;
        int            gap;
        void'($urandom(32'h343b));
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        inst_pc    = '0;
        pc         = 32'h0000_1000;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);  // Idle, nothing may retire
        for (int n = 0; n < NUM_INSTS; n++) begin
            gap = $urandom_range(0, 1) ? 0 : $urandom_range(1, 2);
            repeat (gap) begin
                @(posedge clk);
                inst_valid <= 1'b0;
            end
            @(posedge clk);
            make_inst(in);
            predict_retire(in, pc, e);
            e.due = ncyc + 3;
            expect_q.push_back(e);
            inst_valid <= 1'b1;
            inst       <= in;
            inst_pc    <= pc;
            pc = e.next_pc;  // Follow the control flow like a fetcher
        end
        @(posedge clk);
        inst_valid <= 1'b0;
        wait (expect_q.size() == 0);
        repeat (2) @(negedge clk);
        $display("Errors: %0d, retirements checked: %0d", errors, retired);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    always @(negedge clk) begin : check_retire
        exp_t head;
        ncyc = ncyc + 1;
        if (rst_n) begin
            if (expect_q.size() > 0 && expect_q[0].due == ncyc) begin
                head = expect_q.pop_front();
                retired++;
                check_value("retire_valid", 32'd1, 32'(retire_valid));
                check_value("retire_pc", head.pc, retire_pc);
                check_value("retire_we", 32'(head.we), 32'(retire_we));
                check_value("retire_trap", 32'(head.trap), 32'(retire_trap));
                check_value("redirect", 32'(head.redirect), 32'(redirect));
                if (head.we) begin
                    check_value("retire_rd", 32'(head.rd), 32'(retire_rd));
                    check_value("retire_wdata", head.wdata, retire_wdata);
                end
                if (head.redirect) check_value("redirect_pc", head.next_pc, redirect_pc);
            end else begin
                check_value("retire_valid", 32'd0, 32'(retire_valid));
                check_value("redirect", 32'd0, 32'(redirect));
            end
        end
    end

    initial begin
        wait (ncyc >= TIMEOUT_CYCLES);
        $display("Timeout after %0d cycles, the run stalled with %0d retirements outstanding",
                 ncyc, expect_q.size());
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
logic/rv_pkg.sv
logic/inst_decode.sv
logic/reg_file.sv
logic/alu_execute.sv
logic/result_commit.sv
logic/rv_core_top.sv
bench/core_tb.sv
